/* common/cordic_pkg.sv */
`default_nettype none

package cordic_pkg;

    // micro-rotations per operation, shifts 0 to ITER-1
    localparam int ITER = 11;
    localparam int CNT_WIDTH = $clog2(ITER);

    // atan(2^-i) in the same fixed-point scale as the samples
    localparam fxp_pkg::sample_t ATAN_TABLE [0:ITER-1] = '{
        14'sd804, 14'sd475, 14'sd251, 14'sd127, 14'sd64, 14'sd32,
        14'sd16, 14'sd8, 14'sd4, 14'sd2, 14'sd1
    };

    // inverse CORDIC gain for a full run of ITER steps
    localparam int GAIN_WIDTH = fxp_pkg::FRAC_BITS;
    localparam fxp_pkg::sample_t GAIN = 14'sd622;

    // input register + ITER steps + gain register
    localparam int LATENCY = ITER + 2;

    typedef enum logic {
        ROTATE = 1'b0,
        VECTOR = 1'b1
    } mode_e;

    typedef struct packed {
        mode_e            mode;
        fxp_pkg::sample_t x;
        fxp_pkg::sample_t y;
        fxp_pkg::sample_t z;
    } op_t;

endpackage

`default_nettype wire

/* common/fxp_pkg.sv */
`default_nettype none

package fxp_pkg;

    // samples and angles share one width
    localparam int WIDTH = 14;

    // angles are radians scaled by 2^FRAC_BITS
    localparam int FRAC_BITS = 10;

    typedef logic signed [WIDTH-1:0] sample_t;

endpackage

`default_nettype wire

/* common/rot_stage_if.sv */
`timescale 1ns/10ps
`default_nettype none

// one operation handed between stages, valid is a single-cycle strobe
interface rot_stage_if;

    logic               valid;
    cordic_pkg::mode_e  mode;
    fxp_pkg::sample_t   x;
    fxp_pkg::sample_t   y;
    fxp_pkg::sample_t   z;

    modport src (
        output valid,
        output mode,
        output x,
        output y,
        output z
    );

    modport dst (
        input valid,
        input mode,
        input x,
        input y,
        input z
    );

endinterface

`default_nettype wire

/* compile.f */
common/fxp_pkg.sv
common/cordic_pkg.sv
common/rot_stage_if.sv
hw/input_stage.sv
cordic/cordic_engine.sv
hw/gain_stage.sv
hw/givens_top.sv
verif/tb_givens.sv

/* cordic/cordic_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module cordic_engine (
    input  wire logic   clk,
    input  wire logic   rst_n,
    rot_stage_if.dst    in_if,
    rot_stage_if.src    out_if,
    output logic        busy_o
);

    localparam logic [cordic_pkg::CNT_WIDTH-1:0] CNT_LAST =
        cordic_pkg::CNT_WIDTH'(cordic_pkg::ITER - 1);

    logic                               busy_q;
    logic                               done_q;
    logic [cordic_pkg::CNT_WIDTH-1:0]   cnt_q;
    cordic_pkg::mode_e                  mode_q;
    fxp_pkg::sample_t                   x_q;
    fxp_pkg::sample_t                   y_q;
    fxp_pkg::sample_t                   z_q;

    fxp_pkg::sample_t                   x_sft;
    fxp_pkg::sample_t                   y_sft;
    fxp_pkg::sample_t                   atan;
    logic                               dir_pos;
    fxp_pkg::sample_t                   x_nxt;
    fxp_pkg::sample_t                   y_nxt;
    fxp_pkg::sample_t                   z_nxt;

    // counter doubles as shift amount and table index
    assign x_sft = x_q >>> cnt_q;
    assign y_sft = y_q >>> cnt_q;
    assign atan  = cordic_pkg::ATAN_TABLE[cnt_q];

    // drive y toward zero when vectoring, z toward zero when rotating
    assign dir_pos = (mode_q == cordic_pkg::VECTOR) ? (y_q > 0) : (z_q < 0);

    assign x_nxt = dir_pos ? (x_q + y_sft) : (x_q - y_sft);
    assign y_nxt = dir_pos ? (y_q - x_sft) : (y_q + x_sft);
    assign z_nxt = dir_pos ? (z_q + atan) : (z_q - atan);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (in_if.valid) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                // last step, result goes out with the valid pulse
                if (cnt_q == CNT_LAST) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_if.valid) begin
            mode_q <= in_if.mode;
            x_q    <= in_if.x;
            y_q    <= in_if.y;
            z_q    <= in_if.z;
        end else if (busy_q) begin
            x_q <= x_nxt;
            y_q <= y_nxt;
            z_q <= z_nxt;
        end
    end

    assign busy_o = busy_q;

    assign out_if.valid = done_q;
    assign out_if.mode  = mode_q;
    assign out_if.x     = x_q;
    assign out_if.y     = y_q;
    assign out_if.z     = z_q;

endmodule

`default_nettype wire

/* hw/gain_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module gain_stage (
    input  wire logic   clk,
    input  wire logic   rst_n,
    rot_stage_if.dst    in_if,
    output logic        out_valid_o,
    output fxp_pkg::sample_t x_o,
    output fxp_pkg::sample_t y_o,
    output fxp_pkg::sample_t z_o
);

    localparam int PROD_WIDTH = 2 * fxp_pkg::WIDTH;

    logic signed [PROD_WIDTH-1:0]   x_prod;
    logic signed [PROD_WIDTH-1:0]   y_prod;
    logic                           valid_q;
    fxp_pkg::sample_t               x_q;
    fxp_pkg::sample_t               y_q;
    fxp_pkg::sample_t               z_q;

    // signed full-width products, then drop the gain fraction bits
    assign x_prod = in_if.x * cordic_pkg::GAIN;
    assign y_prod = in_if.y * cordic_pkg::GAIN;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_if.valid;
        end
    end

    // result held until the next operation lands
    always_ff @(posedge clk) begin
        if (in_if.valid) begin
            x_q <= x_prod[cordic_pkg::GAIN_WIDTH +: fxp_pkg::WIDTH];
            y_q <= y_prod[cordic_pkg::GAIN_WIDTH +: fxp_pkg::WIDTH];
            z_q <= in_if.z;
        end
    end

    assign out_valid_o = valid_q;
    assign x_o = x_q;
    assign y_o = y_q;
    assign z_o = z_q;

endmodule

`default_nettype wire

/* hw/givens_top.sv */
`timescale 1ns/10ps
`default_nettype none

module givens_top (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           in_valid_i,
    input  cordic_pkg::mode_e   mode_i,
    input  fxp_pkg::sample_t    x_i,
    input  fxp_pkg::sample_t    y_i,
    input  fxp_pkg::sample_t    angle_i,
    output logic                in_ready_o,
    output logic                out_valid_o,
    output fxp_pkg::sample_t    x_o,
    output fxp_pkg::sample_t    y_o,
    output fxp_pkg::sample_t    z_o
);

    logic core_busy;

    rot_stage_if in2core ();
    rot_stage_if core2gain ();

    input_stage i_input_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid_i (in_valid_i),
        .mode_i     (mode_i),
        .x_i        (x_i),
        .y_i        (y_i),
        .angle_i    (angle_i),
        .busy_i     (core_busy),
        .in_ready_o (in_ready_o),
        .out_if     (in2core.src)
    );

    cordic_engine i_cordic_engine (
        .clk    (clk),
        .rst_n  (rst_n),
        .in_if  (in2core.dst),
        .out_if (core2gain.src),
        .busy_o (core_busy)
    );

    gain_stage i_gain_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_if       (core2gain.dst),
        .out_valid_o (out_valid_o),
        .x_o         (x_o),
        .y_o         (y_o),
        .z_o         (z_o)
    );

endmodule

`default_nettype wire

/* hw/input_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module input_stage (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              in_valid_i,
    input  cordic_pkg::mode_e      mode_i,
    input  fxp_pkg::sample_t       x_i,
    input  fxp_pkg::sample_t       y_i,
    input  fxp_pkg::sample_t       angle_i,
    input  wire logic              busy_i,
    output logic                   in_ready_o,
    rot_stage_if.src               out_if
);

    logic              pending_q;
    logic              accept;
    cordic_pkg::op_t   op_q;

    // no new operation while one waits here or the engine is rotating
    assign in_ready_o = !pending_q && !busy_i;
    assign accept = in_valid_i && in_ready_o;

    // the engine never stalls, so it takes the op on the very next edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q.mode <= mode_i;
            op_q.x    <= x_i;
            op_q.y    <= y_i;
            // vectoring accumulates the angle from zero
            if (mode_i == cordic_pkg::VECTOR) begin
                op_q.z <= '0;
            end else begin
                op_q.z <= angle_i;
            end
        end
    end

    assign out_if.valid = pending_q;
    assign out_if.mode  = op_q.mode;
    assign out_if.x     = op_q.x;
    assign out_if.y     = op_q.y;
    assign out_if.z     = op_q.z;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the givens testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_givens -f compile.f -o sim_givens

# a failing run still prints its output before the verdict
out=$(./obj_dir/sim_givens 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1

/* verif/tb_givens.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_givens;

    localparam int PERIOD = 40;
    localparam int RESET_CYCLES = 8;
    localparam int SUSTAINED_OPS = 40;
    // directed operations and busy strobes plus the random run
    localparam int NUM_OPS = 25 + SUSTAINED_OPS;
    localparam int WATCHDOG_NS = NUM_OPS * (cordic_pkg::LATENCY + 4) * PERIOD
                                 + RESET_CYCLES * PERIOD;
    localparam int WAIT_LIMIT = 2 * cordic_pkg::LATENCY + 8;

    // each rotation pair is turned by every angle
    localparam int ROT_X [0:2] = '{1000, 700, -500};
    localparam int ROT_Y [0:2] = '{0, -300, 800};
    localparam int ROT_A [0:4] = '{804, -804, 0, 1608, -1608};
    // four quadrants then the positive x axis and both y half axes
    localparam int VEC_X [0:6] = '{1200, -900, -600, 800, 1500, 0, 0};
    localparam int VEC_Y [0:6] = '{500, 700, -1100, -400, 0, 900, -900};

    logic               clk;
    logic               rst_n;
    logic               in_valid_i;
    cordic_pkg::mode_e  mode_i;
    fxp_pkg::sample_t   x_i;
    fxp_pkg::sample_t   y_i;
    fxp_pkg::sample_t   angle_i;
    logic               in_ready_o;
    logic               out_valid_o;
    fxp_pkg::sample_t   x_o;
    fxp_pkg::sample_t   y_o;
    fxp_pkg::sample_t   z_o;

    int                 seed;
    fxp_pkg::sample_t   exp_x_q [$];
    fxp_pkg::sample_t   exp_y_q [$];
    fxp_pkg::sample_t   exp_z_q [$];
    time                issue_t_q [$];

    givens_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (in_valid_i),
        .mode_i      (mode_i),
        .x_i         (x_i),
        .y_i         (y_i),
        .angle_i     (angle_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .x_o         (x_o),
        .y_o         (y_o),
        .z_o         (z_o)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic signed [31:0] actual,
                               input logic signed [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("Error at %0t ns: %s = %0d, expected %0d",
                                     $time, name, actual, expected));
        end
    endtask

    // micro-rotations then gain compensation on x and y
    function automatic void model_givens(input cordic_pkg::mode_e mode,
                                         input fxp_pkg::sample_t x_in,
                                         input fxp_pkg::sample_t y_in,
                                         input fxp_pkg::sample_t a_in,
                                         output fxp_pkg::sample_t x_out,
                                         output fxp_pkg::sample_t y_out,
                                         output fxp_pkg::sample_t z_out);
        fxp_pkg::sample_t x, y, z, x_old, y_old;
        logic signed [2*fxp_pkg::WIDTH-1:0] prod;
        logic positive;
        int i;
        x = x_in;
        y = y_in;
        z = (mode == cordic_pkg::VECTOR) ? '0 : a_in;
        for (i = 0; i < cordic_pkg::ITER; i++) begin
            x_old = x;
            y_old = y;
            positive = (mode == cordic_pkg::VECTOR) ? (y_old > 0) : (z < 0);
            if (positive) begin
                x = x_old + (y_old >>> i);
                y = y_old - (x_old >>> i);
                z = z + cordic_pkg::ATAN_TABLE[i];
            end else begin
                x = x_old - (y_old >>> i);
                y = y_old + (x_old >>> i);
                z = z - cordic_pkg::ATAN_TABLE[i];
            end
        end
        prod = x;
        prod = prod * cordic_pkg::GAIN;
        x_out = fxp_pkg::sample_t'(prod >>> cordic_pkg::GAIN_WIDTH);
        prod = y;
        prod = prod * cordic_pkg::GAIN;
        y_out = fxp_pkg::sample_t'(prod >>> cordic_pkg::GAIN_WIDTH);
        z_out = z;
    endfunction

    function automatic fxp_pkg::sample_t rand_sample();
        int r;
        r = $random(seed) % 2001;
        return fxp_pkg::sample_t'(r);
    endfunction

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!in_ready_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready_o) begin
            report_failure("in_ready_o stayed low, no operation could be issued");
        end
    endtask

    // returns on the falling edge after the accepting edge
    task automatic issue_op(input cordic_pkg::mode_e mode, input fxp_pkg::sample_t x,
                            input fxp_pkg::sample_t y, input fxp_pkg::sample_t angle);
        fxp_pkg::sample_t ex, ey, ez;
        wait_ready();
        model_givens(mode, x, y, angle, ex, ey, ez);
        exp_x_q.push_back(ex);
        exp_y_q.push_back(ey);
        exp_z_q.push_back(ez);
        issue_t_q.push_back($time);
        mode_i = mode;
        x_i = x;
        y_i = y;
        angle_i = angle;
        in_valid_i = 1'b1;
        @(negedge clk);
        in_valid_i = 1'b0;
    endtask

    task automatic strobe_inputs(input cordic_pkg::mode_e mode, input fxp_pkg::sample_t x,
                                 input fxp_pkg::sample_t y, input fxp_pkg::sample_t angle);
        mode_i = mode;
        x_i = x;
        y_i = y;
        angle_i = angle;
        in_valid_i = 1'b1;
        @(negedge clk);
        in_valid_i = 1'b0;
    endtask

    task automatic collect_result();
        int waited;
        int cycles;
        fxp_pkg::sample_t ex, ey, ez;
        time t_issue;
        waited = 0;
        @(negedge clk);
        while (!out_valid_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!out_valid_o) begin
            report_failure("out_valid_o never rose for an accepted operation");
        end else if (exp_x_q.size() == 0) begin
            report_failure("out_valid_o rose with no operation outstanding");
        end else begin
            ex = exp_x_q.pop_front();
            ey = exp_y_q.pop_front();
            ez = exp_z_q.pop_front();
            t_issue = issue_t_q.pop_front();
            // issued half a cycle before acceptance and sampled half a cycle after the result
            cycles = int'(($time - t_issue) / PERIOD) - 1;
            check_value("latency", 32'(cycles), 32'(cordic_pkg::LATENCY));
            check_value("x_o", 32'(x_o), 32'(ex));
            check_value("y_o", 32'(y_o), 32'(ey));
            check_value("z_o", 32'(z_o), 32'(ez));
            @(negedge clk);
            check_value("out_valid_o", 32'(out_valid_o), 32'd0);
            check_value("x_o", 32'(x_o), 32'(ex));
            check_value("y_o", 32'(y_o), 32'(ey));
            check_value("z_o", 32'(z_o), 32'(ez));
        end
    endtask

    task automatic check_reset_state();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("out_valid_o", 32'(out_valid_o), 32'd0);
        check_value("in_ready_o", 32'(in_ready_o), 32'd1);
    endtask

    task automatic run_rotation_cases();
        int p, a;
        for (p = 0; p < 3; p++) begin
            for (a = 0; a < 5; a++) begin
                issue_op(cordic_pkg::ROTATE, fxp_pkg::sample_t'(ROT_X[p]),
                         fxp_pkg::sample_t'(ROT_Y[p]), fxp_pkg::sample_t'(ROT_A[a]));
                collect_result();
            end
        end
    endtask

    task automatic run_vectoring_cases();
        int p;
        for (p = 0; p < 7; p++) begin
            // nonzero angle that the DUT must not use
            issue_op(cordic_pkg::VECTOR, fxp_pkg::sample_t'(VEC_X[p]),
                     fxp_pkg::sample_t'(VEC_Y[p]), 14'sd777);
            collect_result();
        end
    endtask

    task automatic check_busy_protection();
        issue_op(cordic_pkg::ROTATE, 14'sd900, -14'sd400, 14'sd500);
        check_value("in_ready_o", 32'(in_ready_o), 32'd0);
        strobe_inputs(cordic_pkg::VECTOR, -14'sd1500, 14'sd1200, 14'sd300);
        repeat (4) @(negedge clk);
        check_value("in_ready_o", 32'(in_ready_o), 32'd0);
        strobe_inputs(cordic_pkg::ROTATE, 14'sd1700, 14'sd1700, -14'sd1000);
        collect_result();
        repeat (cordic_pkg::LATENCY + 4) begin
            @(negedge clk);
            check_value("out_valid_o", 32'(out_valid_o), 32'd0);
        end
    endtask

    task automatic issue_random_ops(input int count);
        cordic_pkg::mode_e mode;
        repeat (count) begin
            mode = (($random(seed) & 1) != 0) ? cordic_pkg::VECTOR : cordic_pkg::ROTATE;
            issue_op(mode, rand_sample(), rand_sample(), rand_sample());
        end
    endtask

    task automatic run_sustained_traffic();
        fork
            issue_random_ops(SUSTAINED_OPS);
            repeat (SUSTAINED_OPS) collect_result();
        join
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before the tests finished");
    end

    initial begin
        seed = 90;
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid_i = 1'b0;
        mode_i = cordic_pkg::ROTATE;
        x_i = '0;
        y_i = '0;
        angle_i = '0;
        check_reset_state();
        run_rotation_cases();
        run_vectoring_cases();
        check_busy_protection();
        run_sustained_traffic();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
